// File: adc_pkg.sv
package adc_pkg;

  // ****************************************
  // Link geometry
  // ****************************************

  // Channels on the receive side, one port pair each at the top level
  localparam int NUM_CH = 2;

  // Bits per converter sample
  localparam int SAMPLE_W = 16;

  // ****************************************
  // Types
  // ****************************************

  // One ADC word as it arrives on the link
  // Upper half holds the later sample of the pair
  typedef struct packed {
    logic [SAMPLE_W-1:0] sample_hi;
    logic [SAMPLE_W-1:0] sample_lo;
  } adc_word_t;

  // One flag per channel, bit index is the channel number
  typedef logic [NUM_CH-1:0] ch_bits_t;

endpackage

// File: pn_pkg.sv
package pn_pkg;

  // ****************************************
  // Pattern selection and status
  // ****************************************

  // Test pattern the channel is told to expect
  // Encoding matches the processor-side select field
  typedef enum logic [0:0] {
    PN9  = 1'b0,
    PN23 = 1'b1
  } pn_seq_e;

  // Live checker state for one channel
  typedef struct packed {
    // High while the prediction does not track the data
    logic oos;
    // One-cycle pulse per bad word while locked
    logic err;
  } pn_status_t;

  // ****************************************
  // Sequence generators
  // ****************************************

  // Tap positions, counted as bits back from the newest bit minus one
  // PN9 is x^9 + x^5 + 1
  localparam int PN9_TAP_LONG   = 8;
  localparam int PN9_TAP_SHORT  = 4;
  // PN23 is x^23 + x^18 + 1
  localparam int PN23_TAP_LONG  = 22;
  localparam int PN23_TAP_SHORT = 17;

  // Runs a two-tap Fibonacci LFSR for 32 steps
  // Newest bit enters at the LSB, so after 32 steps bit 31 is the
  // first bit produced and bit 0 the last one
  function automatic logic [31:0] pn_step32(
    input logic [31:0] din,
    input int          tap_long,
    input int          tap_short
  );
    logic [31:0] state;
    logic        fb;
    state = din;
    for (int i = 0; i < 32; i++) begin
      fb    = state[tap_long] ^ state[tap_short];
      state = {state[30:0], fb};
    end
    return state;
  endfunction

  // Next 32 bits of PN9, seeded from the previous word
  // Only the low 9 bits of the seed matter
  function automatic logic [31:0] pn9_next(input logic [31:0] din);
    return pn_step32(din, PN9_TAP_LONG, PN9_TAP_SHORT);
  endfunction

  // Next 32 bits of PN23, seeded from the previous word
  // Only the low 23 bits of the seed matter
  function automatic logic [31:0] pn23_next(input logic [31:0] din);
    return pn_step32(din, PN23_TAP_LONG, PN23_TAP_SHORT);
  endfunction

endpackage

// File: pn_channel_mon.sv
module pn_channel_mon (
  input  logic               adc_clk,
  input  logic               arst_n,
  // Raw word from the link, samples in wire order
  input  adc_pkg::adc_word_t adc_data,
  // Pattern to predict
  input  pn_pkg::pn_seq_e    seq_sel,
  // From the sync checker, selects the reseed path
  input  logic               oos,
  // Received word in stream order
  output logic [31:0]        data_in,
  // Predicted word, aligned with data_in
  output logic [31:0]        data_pn
);

  import pn_pkg::*;

  // ****************************************
  // Prediction seed and next word
  // ****************************************

  logic [31:0] seed;
  logic [31:0] pn_next;

  // Out of sync: restart from what was actually received
  // In sync: free-run on the previous prediction so errors do not propagate
  assign seed = oos ? data_in : data_pn;

  always_comb begin
    if (seq_sel == PN23) begin
      pn_next = pn23_next(seed);
    end else begin
      pn_next = pn9_next(seed);
    end
  end

  // ****************************************
  // Registers
  // ****************************************

  // Both words are registered together so they compare in the same cycle
  // Zero after reset never counts as a match downstream
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      data_in <= '0;
      data_pn <= '0;
    end else begin
      // Earlier sample sits in the low half on the wire
      data_in <= {adc_data.sample_lo, adc_data.sample_hi};
      data_pn <= pn_next;
    end
  end

endmodule

// File: pn_sync_checker.sv
module pn_sync_checker #(
  // Consecutive matches to lock, consecutive mismatches to lose lock
  parameter int OOS_COUNT = 16
) (
  input  logic               adc_clk,
  input  logic               arst_n,
  // Received and predicted words from the channel monitor
  input  logic [31:0]        data_in,
  input  logic [31:0]        data_pn,
  // Out-of-sync level and error pulse
  output pn_pkg::pn_status_t status
);

  // Counter wide enough to hold OOS_COUNT - 1
  localparam int CNT_W = $clog2(OOS_COUNT + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(OOS_COUNT - 1);

  logic             match;
  logic             match_q;
  logic [CNT_W-1:0] run_cnt;
  logic             oos_q;
  logic             err_q;

  // ****************************************
  // Compare stage
  // ****************************************

  // An all-zero word is a dead link, not a valid pattern word
  assign match = (data_in == data_pn) && (data_in != '0);

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      match_q <= 1'b0;
    end else begin
      match_q <= match;
    end
  end

  // ****************************************
  // Sync state and error pulse
  // ****************************************

  // run_cnt counts events that push toward the other state
  // Any event that agrees with the current state restarts it
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      oos_q   <= 1'b1;
      err_q   <= 1'b0;
      run_cnt <= '0;
    end else begin
      // Bad word while locked, including the one that breaks lock
      err_q <= ~oos_q & ~match_q;
      if (oos_q) begin
        // Hunting for lock
        if (!match_q) begin
          run_cnt <= '0;
        end else if (run_cnt == CNT_LAST) begin
          oos_q   <= 1'b0;
          run_cnt <= '0;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end else begin
        // Locked, watch for a burst of mismatches
        if (match_q) begin
          run_cnt <= '0;
        end else if (run_cnt == CNT_LAST) begin
          oos_q   <= 1'b1;
          run_cnt <= '0;
        end else begin
          run_cnt <= run_cnt + 1'b1;
        end
      end
    end
  end

  assign status.oos = oos_q;
  assign status.err = err_q;

endmodule

// File: pn_status_ctrl.sv
module pn_status_ctrl #(
  // Width of each saturating error counter
  parameter int ERR_CNT_W = 16
) (
  input  logic                                  adc_clk,
  input  logic                                  arst_n,
  // Processor-side selection write
  input  logic                                  pnseq_sel_wr,
  input  pn_pkg::pn_seq_e [adc_pkg::NUM_CH-1:0] pnseq_sel_in,
  // Clears sticky flags and counters
  input  logic                                  status_clr,
  // Live status from the two checkers
  input  pn_pkg::pn_status_t                    status_0,
  input  pn_pkg::pn_status_t                    status_1,
  // Selection to each channel monitor
  output pn_pkg::pn_seq_e                       seq_sel_0,
  output pn_pkg::pn_seq_e                       seq_sel_1,
  // Status seen by the processor
  output adc_pkg::ch_bits_t                     pn_oos,
  output adc_pkg::ch_bits_t                     pn_err_sticky,
  output logic [ERR_CNT_W-1:0]                  err_count_0,
  output logic [ERR_CNT_W-1:0]                  err_count_1
);

  import adc_pkg::*;
  import pn_pkg::*;

  pn_seq_e [NUM_CH-1:0] sel_q;
  pn_status_t           ch_status [NUM_CH];
  logic [ERR_CNT_W-1:0] err_cnt_q [NUM_CH];

  // Per-channel view of the checker status
  assign ch_status[0] = status_0;
  assign ch_status[1] = status_1;

  // ****************************************
  // Pattern selection
  // ****************************************

  // Both channels load together on the strobe
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        sel_q[ch] <= PN9;
      end
    end else if (pnseq_sel_wr) begin
      sel_q <= pnseq_sel_in;
    end
  end

  assign seq_sel_0 = sel_q[0];
  assign seq_sel_1 = sel_q[1];

  // Live lock state, no registering
  always_comb begin
    for (int ch = 0; ch < NUM_CH; ch++) begin
      pn_oos[ch] = ch_status[ch].oos;
    end
  end

  // ****************************************
  // Sticky flags and error counters
  // ****************************************

  // Clear has priority over an error in the same cycle
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_err_sticky <= '0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        err_cnt_q[ch] <= '0;
      end
    end else if (status_clr) begin
      pn_err_sticky <= '0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        err_cnt_q[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (ch_status[ch].err) begin
          pn_err_sticky[ch] <= 1'b1;
          // Hold at all ones instead of wrapping
          if (err_cnt_q[ch] != {ERR_CNT_W{1'b1}}) begin
            err_cnt_q[ch] <= err_cnt_q[ch] + 1'b1;
          end
        end
      end
    end
  end

  assign err_count_0 = err_cnt_q[0];
  assign err_count_1 = err_cnt_q[1];

endmodule

// File: adc_pn_top.sv
module adc_pn_top #(
  parameter int OOS_COUNT = 16,
  parameter int ERR_CNT_W = 16
) (
  input  logic                                  adc_clk,
  input  logic                                  arst_n,
  // Link words, one per channel per clock
  input  adc_pkg::adc_word_t                    adc_data_0,
  input  adc_pkg::adc_word_t                    adc_data_1,
  // Processor side
  input  logic                                  pnseq_sel_wr,
  input  pn_pkg::pn_seq_e [adc_pkg::NUM_CH-1:0] pnseq_sel_in,
  input  logic                                  status_clr,
  output adc_pkg::ch_bits_t                     pn_oos,
  output adc_pkg::ch_bits_t                     pn_err_sticky,
  output logic [ERR_CNT_W-1:0]                  err_count_0,
  output logic [ERR_CNT_W-1:0]                  err_count_1
);

  import pn_pkg::*;

  pn_seq_e     seq_sel_0;
  pn_seq_e     seq_sel_1;
  logic [31:0] data_in_0;
  logic [31:0] data_pn_0;
  logic [31:0] data_in_1;
  logic [31:0] data_pn_1;
  pn_status_t  status_0;
  pn_status_t  status_1;

  // ****************************************
  // Selection and status registers
  // ****************************************

  pn_status_ctrl #(
    .ERR_CNT_W (ERR_CNT_W)
  ) u_ctrl (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .pnseq_sel_wr  (pnseq_sel_wr),
    .pnseq_sel_in  (pnseq_sel_in),
    .status_clr    (status_clr),
    .status_0      (status_0),
    .status_1      (status_1),
    .seq_sel_0     (seq_sel_0),
    .seq_sel_1     (seq_sel_1),
    .pn_oos        (pn_oos),
    .pn_err_sticky (pn_err_sticky),
    .err_count_0   (err_count_0),
    .err_count_1   (err_count_1)
  );

  // ****************************************
  // Channel 0
  // ****************************************

  pn_channel_mon u_mon_0 (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .adc_data (adc_data_0),
    .seq_sel  (seq_sel_0),
    .oos      (status_0.oos),
    .data_in  (data_in_0),
    .data_pn  (data_pn_0)
  );

  pn_sync_checker #(
    .OOS_COUNT (OOS_COUNT)
  ) u_chk_0 (
    .adc_clk (adc_clk),
    .arst_n  (arst_n),
    .data_in (data_in_0),
    .data_pn (data_pn_0),
    .status  (status_0)
  );

  // ****************************************
  // Channel 1
  // ****************************************

  pn_channel_mon u_mon_1 (
    .adc_clk  (adc_clk),
    .arst_n   (arst_n),
    .adc_data (adc_data_1),
    .seq_sel  (seq_sel_1),
    .oos      (status_1.oos),
    .data_in  (data_in_1),
    .data_pn  (data_pn_1)
  );

  pn_sync_checker #(
    .OOS_COUNT (OOS_COUNT)
  ) u_chk_1 (
    .adc_clk (adc_clk),
    .arst_n  (arst_n),
    .data_in (data_in_1),
    .data_pn (data_pn_1),
    .status  (status_1)
  );

endmodule

// File: tb_adc_pn_top.sv
module tb_adc_pn_top;

  timeunit 1ns;
  timeprecision 1ps;

  import adc_pkg::*;
  import pn_pkg::*;

  // ****************************************
  // Test constants
  // ****************************************

  localparam int OOS_COUNT   = 16;
  localparam int ERR_CNT_W   = 16;
  localparam int CLK_PERIOD  = 20;
  // Inputs change this long after the rising edge
  localparam int DRIVE_DLY   = 2;
  localparam int RESET_CYC   = 10;
  // Clean words closing each row so the 4-cycle error path settles
  localparam int DRAIN       = 6;
  // First word index that may be corrupted
  localparam int CORR_START  = 4;
  localparam int MAX_WORDS   = 256;
  localparam int NUM_ROWS    = 4;
  localparam int WDOG_MARGIN = 200;

  // One row of the stimulus table
  typedef struct packed {
    pn_seq_e [NUM_CH-1:0]                sel;
    // Pattern actually sent on the link
    pn_seq_e [NUM_CH-1:0]                pat;
    logic                                clr;
    logic [15:0]                         n_words;
    logic [NUM_CH-1:0][3:0]              n_corr;
    // OOS_COUNT corrupt words in a row near the end
    ch_bits_t                            burst;
    // Must lock within OOS_COUNT + 3 words of the row start
    ch_bits_t                            lock_chk;
    // pn_oos holds its final value for every word of the row
    ch_bits_t                            steady;
    ch_bits_t                            exp_oos;
    logic [NUM_CH-1:0][ERR_CNT_W-1:0]    exp_cnt;
  } row_t;

  logic                 adc_clk;
  logic                 arst_n;
  adc_word_t            data_drv [NUM_CH];
  adc_word_t            adc_data_0;
  adc_word_t            adc_data_1;
  logic                 pnseq_sel_wr;
  pn_seq_e [NUM_CH-1:0] pnseq_sel_in;
  logic                 status_clr;
  ch_bits_t             pn_oos;
  ch_bits_t             pn_err_sticky;
  logic [ERR_CNT_W-1:0] err_count_0;
  logic [ERR_CNT_W-1:0] err_count_1;
  logic [ERR_CNT_W-1:0] cnt [NUM_CH];

  row_t                 rows [NUM_ROWS];
  // Bit history of each source with hist[k-1] the bit from k steps ago
  logic [22:0]          hist [NUM_CH];
  logic [MAX_WORDS-1:0] corr_map [NUM_CH];
  int                   seed = 32'h6af0ac1c;
  int                   n_checks = 0;
  int                   n_errors = 0;

  assign adc_data_0 = data_drv[0];
  assign adc_data_1 = data_drv[1];
  assign cnt[0]     = err_count_0;
  assign cnt[1]     = err_count_1;

  adc_pn_top #(
    .OOS_COUNT (OOS_COUNT),
    .ERR_CNT_W (ERR_CNT_W)
  ) uut (
    .adc_clk       (adc_clk),
    .arst_n        (arst_n),
    .adc_data_0    (adc_data_0),
    .adc_data_1    (adc_data_1),
    .pnseq_sel_wr  (pnseq_sel_wr),
    .pnseq_sel_in  (pnseq_sel_in),
    .status_clr    (status_clr),
    .pn_oos        (pn_oos),
    .pn_err_sticky (pn_err_sticky),
    .err_count_0   (err_count_0),
    .err_count_1   (err_count_1)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // ****************************************
  // Reference PN source
  // ****************************************

  // Next 32 stream bits with the first produced bit in bit 31
  function automatic logic [31:0] gen_word(input pn_seq_e pat, inout logic [22:0] h);
    logic [31:0] w;
    logic        b;
    int          deg_hi;
    int          deg_lo;
    deg_hi = (pat == PN23) ? 23 : 9;
    deg_lo = (pat == PN23) ? 18 : 5;
    w = '0;
    for (int k = 0; k < 32; k++) begin
      // x^n + x^m + 1 means b[t] = b[t-n] ^ b[t-m]
      b = h[deg_hi-1] ^ h[deg_lo-1];
      h = {h[21:0], b};
      w = {w[30:0], b};
    end
    return w;
  endfunction

  task automatic expect_value(input string what, input int got, input int exp);
    n_checks++;
    assert (got == exp) else begin
      n_errors++;
      $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // ****************************************
  // Stimulus table
  // ****************************************

  task automatic add_row(
    input int       r,
    input pn_seq_e  sel0,
    input pn_seq_e  sel1,
    input pn_seq_e  pat0,
    input pn_seq_e  pat1,
    input logic     clr,
    input int       words,
    input int       corr0,
    input int       corr1,
    input ch_bits_t burst,
    input ch_bits_t lock_chk,
    input ch_bits_t steady,
    input ch_bits_t exp_oos,
    input int       cnt0,
    input int       cnt1
  );
    rows[r].sel[0]     = sel0;
    rows[r].sel[1]     = sel1;
    rows[r].pat[0]     = pat0;
    rows[r].pat[1]     = pat1;
    rows[r].clr        = clr;
    rows[r].n_words    = 16'(words);
    rows[r].n_corr[0]  = 4'(corr0);
    rows[r].n_corr[1]  = 4'(corr1);
    rows[r].burst      = burst;
    rows[r].lock_chk   = lock_chk;
    rows[r].steady     = steady;
    rows[r].exp_oos    = exp_oos;
    rows[r].exp_cnt[0] = ERR_CNT_W'(cnt0);
    rows[r].exp_cnt[1] = ERR_CNT_W'(cnt1);
  endtask

  task automatic build_table();
    // Lock from reset with PN23 on channel 0 and PN9 on channel 1
    add_row(0, PN23, PN9, PN23, PN9, 1'b0, 64, 0, 0,
            2'b00, 2'b11, 2'b00, 2'b00, 0, 0);
    // Isolated errors while locked
    add_row(1, PN23, PN9, PN23, PN9, 1'b0, 200, 5, 3,
            2'b00, 2'b00, 2'b11, 2'b00, 5, 3);
    // Clear and then a burst that knocks channel 0 out of lock
    add_row(2, PN23, PN9, PN23, PN9, 1'b1, 80, 0, 0,
            2'b01, 2'b00, 2'b10, 2'b01, OOS_COUNT, 0);
    // Channel 0 now expects PN9 but still gets PN23
    add_row(3, PN9, PN9, PN23, PN9, 1'b0, 120, 0, 0,
            2'b00, 2'b00, 2'b11, 2'b01, OOS_COUNT, 0);
  endtask

  task automatic place_corruptions(input int ch, input int n_words, input int n_corr,
                                   input logic burst);
    int pos;
    int span;
    int placed;
    corr_map[ch] = '0;
    span   = n_words - DRAIN - CORR_START;
    placed = 0;
    while (placed < n_corr) begin
      pos = CORR_START + int'($unsigned($random(seed)) % span);
      // Each bad word stands alone without neighbours
      if (!corr_map[ch][pos] && !corr_map[ch][pos-1] && !corr_map[ch][pos+1]) begin
        corr_map[ch][pos] = 1'b1;
        placed++;
      end
    end
    if (burst) begin
      for (int i = n_words - DRAIN - OOS_COUNT; i < n_words - DRAIN; i++) begin
        corr_map[ch][i] = 1'b1;
      end
    end
  endtask

  // ****************************************
  // Row runner
  // ****************************************

  task automatic run_row(input int r);
    row_t        row;
    int          lock_idx [NUM_CH];
    int          n;
    logic [31:0] w;
    logic [31:0] mask;
    logic [22:0] h;
    row = rows[r];
    n   = int'(row.n_words);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      lock_idx[ch] = -1;
      place_corruptions(ch, n, int'(row.n_corr[ch]), row.burst[ch]);
    end
    for (int i = 0; i < n; i++) begin
      @(posedge adc_clk);
      #DRIVE_DLY;
      // Sample what the edge just passed produced
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (lock_idx[ch] < 0 && !pn_oos[ch]) begin
          lock_idx[ch] = i;
        end
        if (row.steady[ch]) begin
          expect_value($sformatf("row %0d ch %0d pn_oos during row", r, ch),
                       int'(pn_oos[ch]), int'(row.exp_oos[ch]));
        end
        if (row.clr && i == 2) begin
          expect_value($sformatf("row %0d ch %0d count after clear", r, ch), int'(cnt[ch]), 0);
          expect_value($sformatf("row %0d ch %0d sticky after clear", r, ch),
                       int'(pn_err_sticky[ch]), 0);
        end
        // Drain words are clean, so the last sample holds the row result
        if (i == n - 1) begin
          expect_value($sformatf("row %0d ch %0d pn_oos", r, ch),
                       int'(pn_oos[ch]), int'(row.exp_oos[ch]));
          expect_value($sformatf("row %0d ch %0d err_count", r, ch),
                       int'(cnt[ch]), int'(row.exp_cnt[ch]));
          expect_value($sformatf("row %0d ch %0d pn_err_sticky", r, ch),
                       int'(pn_err_sticky[ch]), int'(row.exp_cnt[ch] != '0));
          if (row.lock_chk[ch]) begin
            n_checks++;
            assert (lock_idx[ch] >= 0 && lock_idx[ch] <= OOS_COUNT + 3) else begin
              n_errors++;
              $display("[ERROR] %0d ns: row %0d ch %0d lock at word %0d, limit %0d",
                       $time, r, ch, lock_idx[ch], OOS_COUNT + 3);
            end
          end
        end
      end
      // Selection write and clear ride along with the first word
      pnseq_sel_wr = (i == 0);
      status_clr   = (i == 0) && row.clr;
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (i == 0) begin
          pnseq_sel_in[ch] = row.sel[ch];
        end
        h        = hist[ch];
        w        = gen_word(row.pat[ch], h);
        hist[ch] = h;
        if (corr_map[ch][i]) begin
          mask = $random(seed);
          if (mask == '0) begin
            mask = 32'h1;
          end
          w = w ^ mask;
        end
        // Halves swapped so the monitor puts them back in stream order
        data_drv[ch] = '{sample_hi: w[15:0], sample_lo: w[31:16]};
      end
    end
  endtask

  // ****************************************
  // Main sequence
  // ****************************************

  initial begin
    arst_n       = 1'b0;
    pnseq_sel_wr = 1'b0;
    status_clr   = 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      pnseq_sel_in[ch] = PN9;
      data_drv[ch]     = '0;
    end
    // Nonzero start state in the low 9 bits as well
    hist[0] = 23'h5a5a5;
    hist[1] = 23'h0c3d7;
    build_table();
    repeat (RESET_CYC) @(posedge adc_clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    @(posedge adc_clk);
    #DRIVE_DLY;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      expect_value($sformatf("reset ch %0d pn_oos", ch), int'(pn_oos[ch]), 1);
      expect_value($sformatf("reset ch %0d pn_err_sticky", ch), int'(pn_err_sticky[ch]), 0);
      expect_value($sformatf("reset ch %0d err_count", ch), int'(cnt[ch]), 0);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog limit follows the word counts in the table
  initial begin
    int total;
    #1;
    total = RESET_CYC + WDOG_MARGIN;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += int'(rows[r].n_words);
    end
    #(total * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", total);
    $display("tests failed");
    $finish;
  end

endmodule

// File: tb.f
adc_pkg.sv
pn_pkg.sv
pn_channel_mon.sv
pn_sync_checker.sv
pn_status_ctrl.sv
adc_pn_top.sv
tb_adc_pn_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the ADC PN checker testbench with Verilator
set -u

TOP=tb_adc_pn_top
BUILD_DIR=obj_dir
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
